/* include/rob_tb_checks.svh */
// testbench compare tasks for rename fields and flags, stimulus LFSR
`ifndef ROB_TB_CHECKS_SVH
`define ROB_TB_CHECKS_SVH

task automatic chk_tag(input string test, input string field, input rob_pkg::prf_tag_t exp,
		input rob_pkg::prf_tag_t act, inout int errors);
	if (act !== exp) begin
		$display("MISMATCH %s %s: expected %0d, actual %0d", test, field, exp, act);
		errors++;
	end
endtask

task automatic chk_areg(input string test, input string field, input rob_pkg::arch_reg_t exp,
		input rob_pkg::arch_reg_t act, inout int errors);
	if (act !== exp) begin
		$display("MISMATCH %s %s: expected %0d, actual %0d", test, field, exp, act);
		errors++;
	end
endtask

task automatic chk_flhead(input string test, input string field, input rob_pkg::fl_head_t exp,
		input rob_pkg::fl_head_t act, inout int errors);
	if (act !== exp) begin
		$display("MISMATCH %s %s: expected %0d, actual %0d", test, field, exp, act);
		errors++;
	end
endtask

task automatic chk_bit(input string test, input string field, input logic exp,
		input logic act, inout int errors);
	if (act !== exp) begin
		$display("MISMATCH %s %s: expected %b, actual %b", test, field, exp, act);
		errors++;
	end
endtask

// galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
endfunction

// one step per bit taken
function automatic logic [63:0] lfsr_take(inout logic [31:0] state, input int nbits);
	logic [63:0] bits;
	bits = '0;
	for (int i = 0; i < nbits; i++) begin
		state = lfsr_next(state);
		bits  = {bits[62:0], state[0]};
	end
	return bits;
endfunction

`endif

/* dv/rob_tb.sv */
// reorder buffer testbench with clock, reset, step table, queue model and result counts
`timescale 1ns/1ps
`default_nettype none

module rob_tb;
	import rob_pkg::*;

	`include "rob_tb_checks.svh"

	localparam int RET_WAIT = 8;  // cycles allowed for a late retire

	typedef enum {K_IDLE, K_DISP, K_DONE, K_RES} kind_e;

	typedef struct {
		string      name;
		kind_e      kind;
		int         off;  // entry offset from the model head
		logic [3:0] f;    // br flag, predicted taken, resolved taken, target matches
		logic [3:0] ex;   // retire, recover, br right, full
	} step_t;

	logic      clk, rst;
	logic      dispatch_i, br_flag_i, br_pred_taken_i;
	logic      done_i, br_done_i, br_taken_i;
	prf_tag_t  old_tag_i, new_tag_i, retire_old_tag_o, retire_new_tag_o;
	arch_reg_t arch_dest_i, retire_arch_dest_o;
	addr_t     pc_i, br_target_i, br_target_res_i;
	fl_head_t  fl_head_i, recover_fl_head_o;
	rob_idx_t  done_idx_i, br_idx_i;
	rob_ptr_t  tail_idx_o;
	logic      full_o, retire_valid_o, recover_o, br_right_o;

	step_t       steps[$];
	int          errors, ntests, mark;
	string       cur;
	logic [31:0] lfsr;

	// queue model, payload kept per slot
	rob_ptr_t  m_head, m_tail;
	prf_tag_t  m_old  [ROB_DEPTH];
	prf_tag_t  m_new  [ROB_DEPTH];
	arch_reg_t m_dest [ROB_DEPTH];
	fl_head_t  m_fl   [ROB_DEPTH];
	addr_t     m_tgt  [ROB_DEPTH];

	rob_top i_rob_top (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic chk_ptr(input string test, input string field, input rob_ptr_t exp,
			input rob_ptr_t act, inout int errs);
		if (act !== exp) begin
			$display("MISMATCH %s %s: expected %0d, actual %0d", test, field, exp, act);
			errs++;
		end
	endtask

	task automatic clear_inputs();
		dispatch_i      = 1'b0;
		old_tag_i       = '0;
		new_tag_i       = '0;
		arch_dest_i     = '0;
		pc_i            = '0;
		br_flag_i       = 1'b0;
		br_pred_taken_i = 1'b0;
		br_target_i     = '0;
		fl_head_i       = '0;
		done_i          = 1'b0;
		done_idx_i      = '0;
		br_done_i       = 1'b0;
		br_idx_i        = '0;
		br_taken_i      = 1'b0;
		br_target_res_i = '0;
	endtask

	function automatic void add_step(input string name, input kind_e kind, input int off,
			input logic [3:0] f, input logic [3:0] ex);
		step_t s;
		s.name = name;
		s.kind = kind;
		s.off  = off;
		s.f    = f;
		s.ex   = ex;
		steps.push_back(s);
	endfunction

	// --------------------------------------------------------------------------
	// step table
	// --------------------------------------------------------------------------
	function automatic void build_table();
		add_step("reset", K_IDLE, 0, 4'b0000, 4'b0000);
		for (int i = 0; i < 4; i++)
			add_step("in_order", K_DISP, 0, 4'b0000, 4'b0000);
		for (int i = 3; i >= 0; i--)
			add_step("in_order", K_DONE, i, 4'b0000, 4'b0000);  // youngest first
		for (int i = 0; i < 4; i++)
			add_step("in_order", K_IDLE, 0, 4'b0000, 4'b1000);
		add_step("in_order", K_IDLE, 0, 4'b0000, 4'b0000);
		for (int i = 0; i < ROB_DEPTH; i++)
			add_step("full", K_DISP, 0, 4'b0000, 4'b0000);
		add_step("full", K_DONE, 0, 4'b0000, 4'b0001);
		add_step("full", K_IDLE, 0, 4'b0000, 4'b1000);  // full drops with the retire
		for (int i = ROB_DEPTH - 2; i >= 0; i--)
			add_step("full", K_DONE, i, 4'b0000, 4'b0000);
		for (int i = 0; i < ROB_DEPTH - 1; i++)
			add_step("full", K_IDLE, 0, 4'b0000, 4'b1000);
		add_step("full", K_IDLE, 0, 4'b0000, 4'b0000);
		add_step("br_right", K_DISP, 0, 4'b1100, 4'b0000);
		add_step("br_right", K_DISP, 0, 4'b0000, 4'b0000);
		add_step("br_right", K_RES, 0, 4'b0011, 4'b0010);
		add_step("br_right", K_DONE, 1, 4'b0000, 4'b0000);
		add_step("br_right", K_DONE, 0, 4'b0000, 4'b0000);
		add_step("br_right", K_IDLE, 0, 4'b0000, 4'b1000);
		add_step("br_right", K_IDLE, 0, 4'b0000, 4'b1000);
		add_step("br_right", K_IDLE, 0, 4'b0000, 4'b0000);
		add_step("br_wrong", K_DISP, 0, 4'b0000, 4'b0000);
		add_step("br_wrong", K_DISP, 0, 4'b1000, 4'b0000);  // predicted not taken
		add_step("br_wrong", K_DISP, 0, 4'b0000, 4'b0000);
		add_step("br_wrong", K_DISP, 0, 4'b0000, 4'b0000);
		add_step("br_wrong", K_RES, 1, 4'b0011, 4'b0100);
		for (int i = 3; i >= 0; i--)
			add_step("br_wrong", K_DONE, i, 4'b0000, 4'b0000);
		add_step("br_wrong", K_IDLE, 0, 4'b0000, 4'b1000);
		add_step("br_wrong", K_IDLE, 0, 4'b0000, 4'b1000);
		add_step("br_wrong", K_IDLE, 0, 4'b0000, 4'b0000);  // squashed entries stay
		add_step("br_wrong", K_IDLE, 0, 4'b0000, 4'b0000);
		add_step("double_wrong", K_DISP, 0, 4'b1100, 4'b0000);
		add_step("double_wrong", K_DISP, 0, 4'b1100, 4'b0000);
		add_step("double_wrong", K_RES, 0, 4'b0001, 4'b0100);
		add_step("double_wrong", K_RES, 1, 4'b0001, 4'b0000);  // blocked cycle
		add_step("double_wrong", K_IDLE, 0, 4'b0000, 4'b0000);
		add_step("double_wrong", K_DONE, 0, 4'b0000, 4'b0000);
		add_step("double_wrong", K_IDLE, 0, 4'b0000, 4'b1000);
		add_step("double_wrong", K_IDLE, 0, 4'b0000, 4'b0000);
	endfunction

	// --------------------------------------------------------------------------
	// one step: drive at the falling edge, check mid cycle, update the model
	// --------------------------------------------------------------------------
	task automatic apply_step(input step_t s);
		rob_idx_t    idx;
		rob_ptr_t    p;
		logic [63:0] rnd;
		int          late;
		idx = m_head[ROB_IDX_W-1:0] + rob_idx_t'(s.off);
		@(negedge clk);
		clear_inputs();
		case (s.kind)
			K_DISP: begin
				idx             = m_tail[ROB_IDX_W-1:0];
				dispatch_i      = 1'b1;
				rnd             = lfsr_take(lfsr, PRF_TAG_W);
				old_tag_i       = rnd[PRF_TAG_W-1:0];
				rnd             = lfsr_take(lfsr, PRF_TAG_W);
				new_tag_i       = rnd[PRF_TAG_W-1:0];
				rnd             = lfsr_take(lfsr, ARCH_REG_W);
				arch_dest_i     = rnd[ARCH_REG_W-1:0];
				pc_i            = lfsr_take(lfsr, XLEN);
				rnd             = lfsr_take(lfsr, FL_HEAD_W);
				fl_head_i       = rnd[FL_HEAD_W-1:0];
				br_flag_i       = s.f[3];
				br_pred_taken_i = s.f[2];
				rnd             = lfsr_take(lfsr, XLEN);
				br_target_i     = s.f[3] ? rnd : '0;
			end
			K_DONE: begin
				done_i     = 1'b1;
				done_idx_i = idx;
			end
			K_RES: begin
				br_done_i       = 1'b1;
				br_idx_i        = idx;
				br_taken_i      = s.f[1];
				br_target_res_i = s.f[0] ? m_tgt[idx] : ~m_tgt[idx];
			end
			default: ;
		endcase
		#10;
		if (s.kind == K_IDLE && s.ex[3]) begin
			late = 0;
			while (!retire_valid_o && late < RET_WAIT) begin
				@(negedge clk);
				#10;
				late++;
			end
			if (!retire_valid_o) begin
				$display("timeout: no retire within %0d cycles in %s", RET_WAIT, s.name);
				errors++;
			end else if (late > 0) begin
				$display("retire came %0d cycles late in %s", late, s.name);
				errors++;
			end
		end
		chk_bit(s.name, "retire_valid", s.ex[3], retire_valid_o, errors);
		chk_bit(s.name, "recover", s.ex[2], recover_o, errors);
		chk_bit(s.name, "br_right", s.ex[1], br_right_o, errors);
		chk_bit(s.name, "full", s.ex[0], full_o, errors);
		chk_ptr(s.name, "tail", m_tail, tail_idx_o, errors);
		if (s.ex[3]) begin
			chk_tag(s.name, "old_tag", m_old[m_head[ROB_IDX_W-1:0]], retire_old_tag_o, errors);
			chk_tag(s.name, "new_tag", m_new[m_head[ROB_IDX_W-1:0]], retire_new_tag_o, errors);
			chk_areg(s.name, "arch_dest", m_dest[m_head[ROB_IDX_W-1:0]], retire_arch_dest_o,
				errors);
			m_head = m_head + rob_ptr_t'(1);
		end
		if (s.ex[2])
			chk_flhead(s.name, "fl_head", m_fl[idx], recover_fl_head_o, errors);
		if (s.kind == K_DISP) begin
			m_old[idx]  = old_tag_i;
			m_new[idx]  = new_tag_i;
			m_dest[idx] = arch_dest_i;
			m_fl[idx]   = fl_head_i;
			m_tgt[idx]  = br_target_i;
			m_tail      = m_tail + rob_ptr_t'(1);
		end
		if (s.kind == K_RES && s.ex[2]) begin
			p = m_head;  // find the branch slot among the live entries
			while (p != m_tail && p[ROB_IDX_W-1:0] != idx)
				p = p + rob_ptr_t'(1);
			if (p == m_tail) begin
				$display("branch at index %0d is not in the queue in %s", idx, s.name);
				errors++;
			end else
				m_tail = p + rob_ptr_t'(1);  // younger entries dropped
		end
	endtask

	task automatic end_test();
		if (cur != "") begin
			if (errors == mark)
				$display("test %-12s ok", cur);
			else
				$display("test %-12s %0d errors", cur, errors - mark);
		end
	endtask

	initial begin
		errors = 0;
		ntests = 0;
		mark   = 0;
		cur    = "";
		lfsr   = 32'h731d;
		m_head = '0;
		m_tail = '0;
		rst    = 1'b1;
		clear_inputs();
		build_table();
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		foreach (steps[i]) begin
			if (steps[i].name != cur) begin
				end_test();
				cur  = steps[i].name;
				mark = errors;
				ntests++;
			end
			apply_step(steps[i]);
		end
		end_test();
		$display("tests %0d, steps %0d, errors %0d", ntests, steps.size(), errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/rob_alloc_if.sv */
// dispatch write bundle from the pointer control to the entry tables
`timescale 1ns/1ps
`default_nettype none

interface rob_alloc_if;
	import rob_pkg::*;

	logic      alloc_we;       // one-cycle write strobe
	rob_idx_t  alloc_idx;      // current tail slot
	prf_tag_t  old_tag;        // previous mapping of the destination
	prf_tag_t  new_tag;        // tag taken from the freelist
	arch_reg_t arch_dest;
	addr_t     pc;
	logic      br_flag;
	logic      br_pred_taken;
	addr_t     br_target;
	fl_head_t  fl_head;        // freelist head at dispatch, for rollback

	modport ctrl (output alloc_we, alloc_idx, old_tag, new_tag, arch_dest, pc,
		br_flag, br_pred_taken, br_target, fl_head);

	// all tables take the same write, each keeps its own fields
	modport tbl (input alloc_we, alloc_idx, old_tag, new_tag, arch_dest, pc,
		br_flag, br_pred_taken, br_target, fl_head);

endinterface

`default_nettype wire

/* hw/rob_branch_table.sv */
// branch fields per entry and the resolved outcome compare
`timescale 1ns/1ps
`default_nettype none

module rob_branch_table (
	input  wire logic              clk,
	rob_alloc_if.tbl               alloc,
	input  wire logic              br_done_i,
	input  wire rob_pkg::rob_idx_t br_idx_i,
	input  wire logic              br_taken_i,
	input  wire rob_pkg::addr_t    br_target_i,
	output logic                   mispredict_o,
	output logic                   br_right_o,
	output rob_pkg::fl_head_t      recover_fl_head_o
);
	import rob_pkg::*;

	// --------------------------------------------------------------------------
	// storage, written at dispatch
	// --------------------------------------------------------------------------
	logic [ROB_DEPTH-1:0] br_flag_q;
	logic [ROB_DEPTH-1:0] br_pred_q;     // predicted direction
	addr_t                br_target_q [ROB_DEPTH];
	fl_head_t             fl_head_q   [ROB_DEPTH];

	always_ff @(posedge clk) begin
		if (alloc.alloc_we) begin
			br_flag_q[alloc.alloc_idx]   <= alloc.br_flag;
			br_pred_q[alloc.alloc_idx]   <= alloc.br_pred_taken;
			br_target_q[alloc.alloc_idx] <= alloc.br_target;
			fl_head_q[alloc.alloc_idx]   <= alloc.fl_head;
		end
	end

	// --------------------------------------------------------------------------
	// resolution compare
	// --------------------------------------------------------------------------
	logic is_branch;
	logic dir_wrong;
	logic tgt_wrong;

	assign is_branch = br_done_i && br_flag_q[br_idx_i];
	assign dir_wrong = (br_pred_q[br_idx_i] != br_taken_i);
	assign tgt_wrong = (br_target_q[br_idx_i] != br_target_i);

	// either mismatch means the younger entries are on the wrong path
	assign mispredict_o = is_branch && (dir_wrong || tgt_wrong);
	assign br_right_o   = is_branch && !dir_wrong && !tgt_wrong;

	// freelist head as it was when the branch dispatched
	assign recover_fl_head_o = fl_head_q[br_idx_i];

endmodule

`default_nettype wire

/* hw/rob_ctrl.sv */
// head and tail pointers, full and retire decision, tail rollback, recovery block
`timescale 1ns/1ps
`default_nettype none

module rob_ctrl (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               dispatch_i,
	input  wire logic               head_done_i,
	input  wire logic               mispredict_i,
	input  wire rob_pkg::rob_idx_t  br_idx_i,
	input  wire rob_pkg::prf_tag_t  old_tag_i,
	input  wire rob_pkg::prf_tag_t  new_tag_i,
	input  wire rob_pkg::arch_reg_t arch_dest_i,
	input  wire rob_pkg::addr_t     pc_i,
	input  wire logic               br_flag_i,
	input  wire logic               br_pred_taken_i,
	input  wire rob_pkg::addr_t     br_target_i,
	input  wire rob_pkg::fl_head_t  fl_head_i,
	rob_alloc_if.ctrl               alloc,
	output rob_pkg::rob_idx_t       head_idx_o,
	output rob_pkg::rob_ptr_t       tail_idx_o,
	output logic                    retire_fire_o,
	output logic                    recover_o,
	output logic                    full_o
);
	import rob_pkg::*;

	rob_ptr_t     head_q, tail_q;
	rob_ptr_t     br_ptr;         // branch slot with its wrap bit restored
	rob_ptr_t     occupancy;
	recov_state_e recov_q;
	logic         empty, dispatch_ok;

	assign empty         = (head_q == tail_q);
	assign retire_fire_o = !empty && head_done_i;
	assign full_o        = ((head_q ^ tail_q) == {1'b1, {ROB_IDX_W{1'b0}}}) && !retire_fire_o;
	assign recover_o     = mispredict_i && (recov_q == RECOV_OPEN);
	assign dispatch_ok   = dispatch_i && !recover_o;  // younger than the branch, drop
	assign occupancy     = tail_q - head_q;

	assign head_idx_o = head_q[ROB_IDX_W-1:0];
	assign tail_idx_o = tail_q;

	// slot below the head index sits in the next lap
	always_comb begin
		br_ptr = {head_q[ROB_IDX_W], br_idx_i};
		if (br_idx_i < head_q[ROB_IDX_W-1:0])
			br_ptr[ROB_IDX_W] = ~head_q[ROB_IDX_W];
	end

	assign alloc.alloc_we      = dispatch_ok;
	assign alloc.alloc_idx     = tail_q[ROB_IDX_W-1:0];
	assign alloc.old_tag       = old_tag_i;
	assign alloc.new_tag       = new_tag_i;
	assign alloc.arch_dest     = arch_dest_i;
	assign alloc.pc            = pc_i;
	assign alloc.br_flag       = br_flag_i;
	assign alloc.br_pred_taken = br_pred_taken_i;
	assign alloc.br_target     = br_target_i;
	assign alloc.fl_head       = fl_head_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q  <= '0;
			tail_q  <= '0;
			recov_q <= RECOV_OPEN;
		end else begin
			if (retire_fire_o)
				head_q <= head_q + 1'b1;
			if (recover_o)
				tail_q <= br_ptr + 1'b1;  // squash everything after the branch
			else if (dispatch_ok)
				tail_q <= tail_q + 1'b1;
			recov_q <= recover_o ? RECOV_BLOCKED : RECOV_OPEN;
		end
	end

	a_no_dispatch_full: assert property (@(posedge clk) disable iff (rst)
		dispatch_i |-> !full_o);

	a_tail_behind_head: assert property (@(posedge clk) disable iff (rst)
		occupancy <= rob_ptr_t'(ROB_DEPTH));

endmodule

`default_nettype wire

/* hw/rob_done_table.sv */
// done bit per entry, cleared on dispatch and retire, set on completion
`timescale 1ns/1ps
`default_nettype none

module rob_done_table (
	input  wire logic              clk,
	input  wire logic              rst,
	rob_alloc_if.tbl               alloc,
	input  wire logic              done_i,
	input  wire rob_pkg::rob_idx_t done_idx_i,
	input  wire rob_pkg::rob_idx_t head_idx_i,
	input  wire logic              retire_fire_i,
	output logic                   head_done_o
);
	import rob_pkg::*;

	logic [ROB_DEPTH-1:0] done_q;
	logic                 last_alloc_q;  // pointers last met through a dispatch
	logic                 buf_empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			done_q       <= '0;
			last_alloc_q <= 1'b0;
		end else begin
			if (alloc.alloc_we)
				done_q[alloc.alloc_idx] <= 1'b0;
			if (retire_fire_i)
				done_q[head_idx_i] <= 1'b0;
			if (done_i)
				done_q[done_idx_i] <= 1'b1;  // completion wins over dispatch
			if (alloc.alloc_we && !retire_fire_i)
				last_alloc_q <= 1'b1;
			else if (retire_fire_i && !alloc.alloc_we)
				last_alloc_q <= 1'b0;
		end
	end

	assign head_done_o = done_q[head_idx_i];
	assign buf_empty   = (head_idx_i == alloc.alloc_idx) && !last_alloc_q;

	a_no_done_empty: assert property (@(posedge clk) disable iff (rst)
		(done_i && buf_empty) |-> (done_idx_i != head_idx_i));

endmodule

`default_nettype wire

/* hw/rob_entry_store.sv */
// rename payload and pc per entry, head entry read
`timescale 1ns/1ps
`default_nettype none

module rob_entry_store (
	input  wire logic               clk,
	rob_alloc_if.tbl                alloc,
	input  wire rob_pkg::rob_idx_t  head_idx_i,
	output rob_pkg::prf_tag_t       head_old_tag_o,
	output rob_pkg::prf_tag_t       head_new_tag_o,
	output rob_pkg::arch_reg_t      head_arch_dest_o
);
	import rob_pkg::*;

	// --------------------------------------------------------------------------
	// entry storage
	// --------------------------------------------------------------------------
	prf_tag_t  old_tag_q   [ROB_DEPTH];  // goes back to the freelist on retire
	prf_tag_t  new_tag_q   [ROB_DEPTH];  // goes to the arch map on retire
	arch_reg_t arch_dest_q [ROB_DEPTH];
	addr_t     pc_q        [ROB_DEPTH];
	addr_t     head_pc;

	always_ff @(posedge clk) begin
		if (alloc.alloc_we) begin
			old_tag_q[alloc.alloc_idx]   <= alloc.old_tag;
			new_tag_q[alloc.alloc_idx]   <= alloc.new_tag;
			arch_dest_q[alloc.alloc_idx] <= alloc.arch_dest;
			pc_q[alloc.alloc_idx]        <= alloc.pc;
		end
	end

	// --------------------------------------------------------------------------
	// head read
	// --------------------------------------------------------------------------
	assign head_old_tag_o   = old_tag_q[head_idx_i];
	assign head_new_tag_o   = new_tag_q[head_idx_i];
	assign head_arch_dest_o = arch_dest_q[head_idx_i];
	assign head_pc          = pc_q[head_idx_i];

	// an entry leaving the head must have been written by a dispatch
	a_retired_pc_known: assert property (@(posedge clk)
		(head_idx_i != $past(head_idx_i)) |-> !$isunknown($past(head_pc)));

endmodule

`default_nettype wire

/* hw/rob_pkg.sv */
// reorder buffer sizes, rename and branch field types, recovery block states
`default_nettype none

package rob_pkg;

	// --------------------------------------------------------------------------
	// sizes
	// --------------------------------------------------------------------------
	localparam int ROB_DEPTH  = 16;
	localparam int ROB_IDX_W  = 4;
	localparam int PRF_TAG_W  = 6;  // physical register file has 64 entries
	localparam int ARCH_REG_W = 5;
	localparam int FL_HEAD_W  = 5;
	localparam int XLEN       = 64;

	// --------------------------------------------------------------------------
	// field types
	// --------------------------------------------------------------------------
	typedef logic [ROB_IDX_W-1:0]  rob_idx_t;
	typedef logic [ROB_IDX_W:0]    rob_ptr_t;  // msb is the wrap bit
	typedef logic [PRF_TAG_W-1:0]  prf_tag_t;
	typedef logic [ARCH_REG_W-1:0] arch_reg_t;
	typedef logic [FL_HEAD_W-1:0]  fl_head_t;
	typedef logic [XLEN-1:0]       addr_t;

	// blocked for one cycle after a recovery so a second wrong branch is ignored
	typedef enum logic {
		RECOV_OPEN    = 1'b0,
		RECOV_BLOCKED = 1'b1
	} recov_state_e;

endpackage

`default_nettype wire

/* hw/rob_top.sv */
// reorder buffer top level, pointer control and entry tables
`timescale 1ns/1ps
`default_nettype none

module rob_top (
	input  wire logic               clk,
	input  wire logic               rst,
	// dispatch
	input  wire logic               dispatch_i,
	input  wire rob_pkg::prf_tag_t  old_tag_i,
	input  wire rob_pkg::prf_tag_t  new_tag_i,
	input  wire rob_pkg::arch_reg_t arch_dest_i,
	input  wire rob_pkg::addr_t     pc_i,
	input  wire logic               br_flag_i,
	input  wire logic               br_pred_taken_i,
	input  wire rob_pkg::addr_t     br_target_i,
	input  wire rob_pkg::fl_head_t  fl_head_i,
	// completion
	input  wire logic               done_i,
	input  wire rob_pkg::rob_idx_t  done_idx_i,
	// branch resolution
	input  wire logic               br_done_i,
	input  wire rob_pkg::rob_idx_t  br_idx_i,
	input  wire logic               br_taken_i,
	input  wire rob_pkg::addr_t     br_target_res_i,
	// status, retire and recovery
	output rob_pkg::rob_ptr_t       tail_idx_o,
	output logic                    full_o,
	output logic                    retire_valid_o,
	output rob_pkg::prf_tag_t       retire_old_tag_o,
	output rob_pkg::prf_tag_t       retire_new_tag_o,
	output rob_pkg::arch_reg_t      retire_arch_dest_o,
	output logic                    recover_o,
	output logic                    br_right_o,
	output rob_pkg::fl_head_t       recover_fl_head_o
);
	import rob_pkg::*;

	rob_idx_t head_idx;
	logic     head_done;
	logic     mispredict;

	rob_alloc_if alloc ();

	rob_ctrl i_rob_ctrl (
		.clk(clk), .rst(rst),
		.dispatch_i(dispatch_i), .head_done_i(head_done), .mispredict_i(mispredict),
		.br_idx_i(br_idx_i),
		.old_tag_i(old_tag_i), .new_tag_i(new_tag_i), .arch_dest_i(arch_dest_i),
		.pc_i(pc_i), .br_flag_i(br_flag_i), .br_pred_taken_i(br_pred_taken_i),
		.br_target_i(br_target_i), .fl_head_i(fl_head_i),
		.alloc(alloc),
		.head_idx_o(head_idx), .tail_idx_o(tail_idx_o),
		.retire_fire_o(retire_valid_o), .recover_o(recover_o), .full_o(full_o)
	);

	rob_entry_store i_rob_entry_store (
		.clk(clk), .alloc(alloc), .head_idx_i(head_idx),
		.head_old_tag_o(retire_old_tag_o), .head_new_tag_o(retire_new_tag_o),
		.head_arch_dest_o(retire_arch_dest_o)
	);

	rob_done_table i_rob_done_table (
		.clk(clk), .rst(rst), .alloc(alloc),
		.done_i(done_i), .done_idx_i(done_idx_i), .head_idx_i(head_idx),
		.retire_fire_i(retire_valid_o), .head_done_o(head_done)
	);

	rob_branch_table i_rob_branch_table (
		.clk(clk), .alloc(alloc),
		.br_done_i(br_done_i), .br_idx_i(br_idx_i), .br_taken_i(br_taken_i),
		.br_target_i(br_target_res_i),
		.mispredict_o(mispredict), .br_right_o(br_right_o),
		.recover_fl_head_o(recover_fl_head_o)
	);

endmodule

`default_nettype wire

/* rob_top.f */
+incdir+include
hw/rob_pkg.sv
hw/rob_alloc_if.sv
hw/rob_ctrl.sv
hw/rob_entry_store.sv
hw/rob_done_table.sv
hw/rob_branch_table.sv
hw/rob_top.sv
dv/rob_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the reorder buffer testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module rob_tb -f rob_top.f -o rob_sim

out=$(./obj_dir/rob_sim 2>&1) || true
printf '%s\n' "$out"

# the script fails unless the pass line is present
printf '%s\n' "$out" | grep -qx 'Simulation PASSED'
